//--- src/rtp_pkg.sv
// ******************************************************************
// rtp packetizer shared definitions
// beat and field widths, protocol constants, serializer states
// ******************************************************************
`default_nettype none

package rtp_pkg;

  typedef logic [63:0] axis_word_t;
  typedef logic [7:0]  axis_keep_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] byte_len_t;
  typedef logic [11:0] pixel_cnt_t;
  typedef logic [15:0] line_num_t;
  typedef logic [31:0] seq_num_t;
  typedef logic [31:0] rtp_ts_t;
  typedef logic [15:0] ip_csum_t;

  // ethernet / ipv4 fixed fields
  localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL    = 8'h45;   // v4, 5 words
  localparam logic [15:0] IP_IDENT      = 16'h0000;
  localparam logic [15:0] IP_FLAGS_DF   = 16'h4000; // df set, offset 0
  localparam logic [7:0]  IP_TTL        = 8'hFF;
  localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;
  localparam logic [15:0] UDP_CSUM      = 16'h0000; // udp checksum not used

  // rtp fixed fields
  localparam logic [1:0]  RTP_VERSION   = 2'd2;
  localparam logic [3:0]  RTP_CSRC_CNT  = 4'd1;
  localparam logic [6:0]  RTP_PT        = 7'd96;   // dynamic, raw video
  localparam logic [31:0] RTP_SSRC      = 32'h0;
  localparam logic [31:0] RTP_CSRC      = 32'h0;
  localparam logic [15:0] RTP_CONT_OFFSET = 16'h0000; // single line, offset 0

  // header sizes in bytes
  localparam byte_len_t UDP_HDR_BYTES = 16'd8;
  localparam byte_len_t RTP_HDR_BYTES = 16'd16; // 12 fixed + 1 csrc
  localparam byte_len_t PL_HDR_BYTES  = 16'd8;
  localparam byte_len_t UDP_OVERHEAD  = UDP_HDR_BYTES + RTP_HDR_BYTES + PL_HDR_BYTES;
  localparam byte_len_t IP_HDR_BYTES  = 16'd20;

  typedef enum logic [2:0] {
    IDLE,
    ETH_HDR,
    IP_HDR,
    UDP_HDR,
    RTP_HDR,
    PAYLOAD
  } pkt_state_t;

endpackage

`default_nettype wire

//--- src/video_stream_if.sv
// ******************************************************************
// video beat stream from the line fifo to the serializer
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

interface video_stream_if;

  logic                valid;
  rtp_pkg::axis_word_t data;  // four 16-bit pixels, first in low bits
  logic                last;  // end of line
  logic                sof;   // start of frame
  logic                ready;

  modport src (output valid, data, last, sof, input ready);
  modport dst (input valid, data, last, sof, output ready);

endinterface

`default_nettype wire

//--- src/rtp_hdr_if.sv
// ******************************************************************
// packet events and per-packet header fields
// between header generator and serializer
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

interface rtp_hdr_if;

  logic                pkt_start;  // serializer leaves idle
  logic                pkt_sof;    // head beat starts a frame
  logic                pkt_done;   // final beat accepted
  rtp_pkg::seq_num_t   seq;
  rtp_pkg::rtp_ts_t    timestamp;
  rtp_pkg::line_num_t  line_num;
  logic                marker;
  rtp_pkg::byte_len_t  udp_len;
  rtp_pkg::byte_len_t  ip_len;
  rtp_pkg::ip_csum_t   ip_csum;

  modport ser (output pkt_start, pkt_sof, pkt_done,
               input seq, timestamp, line_num, marker, udp_len, ip_len, ip_csum);

  modport gen (input pkt_start, pkt_sof, pkt_done,
               output seq, timestamp, line_num, marker, udp_len, ip_len, ip_csum);

endinterface

`default_nettype wire

//--- src/line_fifo.sv
// ******************************************************************
// line fifo
// circular buffer for video beats with end-of-line and sof flags,
// stalls the input when full
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  wire logic                aclk,
  input  wire logic                aresetn,
  input  wire logic                in_valid,
  input  wire rtp_pkg::axis_word_t in_data,
  input  wire logic                in_last,
  input  wire logic                in_sof,
  output logic                     in_ready,
  video_stream_if.src              out
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);
  localparam logic [AW-1:0] LAST_IDX = AW'(FIFO_DEPTH - 1);

  rtp_pkg::axis_word_t data_mem [FIFO_DEPTH];
  logic                last_mem [FIFO_DEPTH];
  logic                sof_mem  [FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          wr_en;
  logic          rd_en;

  assign in_ready = (count != CW'(FIFO_DEPTH));
  assign wr_en    = in_valid & in_ready;
  assign rd_en    = out.valid & out.ready;

  // head of the buffer, visible the cycle after the write
  assign out.valid = (count != '0);
  assign out.data  = data_mem[rd_ptr];
  assign out.last  = last_mem[rd_ptr];
  assign out.sof   = sof_mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= in_data;
      last_mem[wr_ptr] <= in_last;
      sof_mem[wr_ptr]  <= in_sof;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // idle or simultaneous
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/rtp_hdr_gen.sv
// ******************************************************************
// rtp header generator
// sequence, timestamp and line counters, lengths, marker
// and the ipv4 header checksum for each packet
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rtp_hdr_gen #(
  parameter int TS_INCREMENT = 3000
) (
  input  wire logic                aclk,
  input  wire logic                aresetn,
  input  wire rtp_pkg::line_num_t  lines_per_frame,
  input  wire rtp_pkg::pixel_cnt_t px_per_line,
  input  wire logic [7:0]          ip_tos,
  input  wire rtp_pkg::ip_addr_t   src_ip,
  input  wire rtp_pkg::ip_addr_t   dst_ip,
  rtp_hdr_if.gen                   hdr
);

  rtp_pkg::seq_num_t  seq_q;
  rtp_pkg::rtp_ts_t   ts_q;
  rtp_pkg::line_num_t line_q;
  rtp_pkg::line_num_t line_next;
  rtp_pkg::byte_len_t udp_len_q;
  rtp_pkg::byte_len_t ip_len_q;
  rtp_pkg::byte_len_t udp_len_next;
  logic               marker_q;
  logic               start_d;   // lengths valid, sum them now
  logic [19:0]        sum_next;
  logic [19:0]        sum_q;
  logic [16:0]        fold1;
  logic [15:0]        fold2;

  assign line_next    = hdr.pkt_sof ? '0 : line_q + 1'b1;
  assign udp_len_next = {3'b0, px_per_line, 1'b0} + rtp_pkg::UDP_OVERHEAD;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      seq_q    <= '0;
      ts_q     <= '0;
      line_q   <= '0;
      marker_q <= 1'b0;
      start_d  <= 1'b0;
    end else begin
      start_d <= hdr.pkt_start;
      if (hdr.pkt_start) begin
        line_q   <= line_next;
        marker_q <= (line_next == lines_per_frame - 1'b1);  // last line of frame
      end
      if (hdr.pkt_done) begin
        seq_q <= seq_q + 1'b1;
        if (marker_q) begin
          ts_q <= ts_q + rtp_pkg::rtp_ts_t'(TS_INCREMENT);
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (hdr.pkt_start) begin
      udp_len_q <= udp_len_next;
      ip_len_q  <= udp_len_next + rtp_pkg::IP_HDR_BYTES;
    end
  end

  // ******************************************************************
  // ipv4 header checksum, nine 16-bit words with checksum field zero
  // ******************************************************************
  assign sum_next = 20'({rtp_pkg::IP_VER_IHL, ip_tos}) + 20'(ip_len_q) +
                    20'(rtp_pkg::IP_IDENT) + 20'(rtp_pkg::IP_FLAGS_DF) +
                    20'({rtp_pkg::IP_TTL, rtp_pkg::IP_PROTO_UDP}) +
                    20'(src_ip[31:16]) + 20'(src_ip[15:0]) +
                    20'(dst_ip[31:16]) + 20'(dst_ip[15:0]);

  always_ff @(posedge aclk) begin
    if (start_d) begin
      sum_q <= sum_next;
    end
  end

  // end-around carry, second fold catches the carry of the first
  assign fold1 = {1'b0, sum_q[15:0]} + {13'b0, sum_q[19:16]};
  assign fold2 = fold1[15:0] + {15'b0, fold1[16]};

  assign hdr.seq       = seq_q;
  assign hdr.timestamp = ts_q;
  assign hdr.line_num  = line_q;
  assign hdr.marker    = marker_q;
  assign hdr.udp_len   = udp_len_q;
  assign hdr.ip_len    = ip_len_q;
  assign hdr.ip_csum   = ~fold2;

endmodule

`default_nettype wire

//--- src/rtp_pkt_serializer.sv
// ******************************************************************
// rtp packet serializer
// emits the eth/ip/udp/rtp header beats, then the line payload
// shifted by the 2-byte continuation/offset field
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rtp_pkt_serializer (
  input  wire logic                aclk,
  input  wire logic                aresetn,
  input  wire rtp_pkg::mac_addr_t  dst_mac,
  input  wire rtp_pkg::mac_addr_t  src_mac,
  input  wire logic [7:0]          ip_tos,
  input  wire rtp_pkg::ip_addr_t   src_ip,
  input  wire rtp_pkg::ip_addr_t   dst_ip,
  input  wire rtp_pkg::udp_port_t  src_port,
  input  wire rtp_pkg::udp_port_t  dst_port,
  input  wire rtp_pkg::pixel_cnt_t px_per_line,
  video_stream_if.dst              video,
  rtp_hdr_if.ser                   hdr,
  output logic                     m_tvalid,
  output rtp_pkg::axis_word_t      m_tdata,
  output rtp_pkg::axis_keep_t      m_tkeep,
  output logic                     m_tlast,
  input  wire logic                m_tready
);

  rtp_pkg::pkt_state_t state;
  logic [2:0]          beat_cnt;    // header beat being loaded
  logic                flush_pend;  // line consumed, leftover bytes pending
  logic [15:0]         carry;       // last two bytes of previous beat
  logic                load;
  rtp_pkg::axis_word_t hdr_word;    // big endian, first wire byte in [63:56]
  rtp_pkg::axis_word_t pix_be;
  rtp_pkg::byte_len_t  pl_len;

  // wire byte k of a beat goes to lane k, lane 0 in tdata[7:0]
  function automatic rtp_pkg::axis_word_t to_wire(input rtp_pkg::axis_word_t w);
    rtp_pkg::axis_word_t swapped;
    for (int i = 0; i < 8; i++) begin
      swapped[8*i +: 8] = w[63-8*i -: 8];
    end
    return swapped;
  endfunction

  assign load   = !m_tvalid || m_tready;  // output register free
  assign pix_be = {video.data[15:0], video.data[31:16], video.data[47:32], video.data[63:48]};
  assign pl_len = {3'b0, px_per_line, 1'b0};

  assign video.ready   = (state == rtp_pkg::PAYLOAD) && load && !flush_pend;
  assign hdr.pkt_start = (state == rtp_pkg::IDLE) && load && video.valid;
  assign hdr.pkt_sof   = video.sof;
  assign hdr.pkt_done  = m_tvalid && m_tready && m_tlast;

  // ******************************************************************
  // header field placement
  // ******************************************************************
  always_comb begin
    case (beat_cnt)
      3'd0: hdr_word = {dst_mac, src_mac[47:32]};
      3'd1: hdr_word = {src_mac[31:0], rtp_pkg::ETH_TYPE_IPV4, rtp_pkg::IP_VER_IHL, ip_tos};
      3'd2: hdr_word = {hdr.ip_len, rtp_pkg::IP_IDENT, rtp_pkg::IP_FLAGS_DF,
                        rtp_pkg::IP_TTL, rtp_pkg::IP_PROTO_UDP};
      3'd3: hdr_word = {hdr.ip_csum, src_ip, dst_ip[31:16]};
      3'd4: hdr_word = {dst_ip[15:0], src_port, dst_port, hdr.udp_len};
      3'd5: hdr_word = {rtp_pkg::UDP_CSUM, rtp_pkg::RTP_VERSION, 1'b0, 1'b0,
                        rtp_pkg::RTP_CSRC_CNT, hdr.marker, rtp_pkg::RTP_PT,
                        hdr.seq[15:0], hdr.timestamp[31:16]};
      3'd6: hdr_word = {hdr.timestamp[15:0], rtp_pkg::RTP_SSRC, rtp_pkg::RTP_CSRC[31:16]};
      default: hdr_word = {rtp_pkg::RTP_CSRC[15:0], hdr.seq[31:16], pl_len,
                           1'b0, hdr.line_num[14:0]};  // progressive, field 0
    endcase
  end

  // ******************************************************************
  // control, state and output handshake
  // ******************************************************************
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= rtp_pkg::IDLE;
      beat_cnt   <= '0;
      flush_pend <= 1'b0;
      m_tvalid   <= 1'b0;
      m_tlast    <= 1'b0;
    end else if (load) begin
      case (state)
        rtp_pkg::IDLE: begin
          m_tvalid <= video.valid;  // beat 0 goes out with the start
          m_tlast  <= 1'b0;
          if (video.valid) begin
            state    <= rtp_pkg::ETH_HDR;
            beat_cnt <= 3'd1;
          end
        end
        rtp_pkg::PAYLOAD: begin
          m_tvalid <= flush_pend || video.valid;
          m_tlast  <= flush_pend;
          if (flush_pend) begin
            flush_pend <= 1'b0;
            state      <= rtp_pkg::IDLE;
          end else if (video.valid && video.last) begin
            flush_pend <= 1'b1;
          end
        end
        default: begin
          m_tvalid <= 1'b1;
          m_tlast  <= 1'b0;
          beat_cnt <= beat_cnt + 1'b1;
          case (beat_cnt)
            3'd1:    state <= rtp_pkg::IP_HDR;
            3'd4:    state <= rtp_pkg::UDP_HDR;
            3'd5:    state <= rtp_pkg::RTP_HDR;
            3'd7:    state <= rtp_pkg::PAYLOAD;
            default: state <= state;
          endcase
        end
      endcase
    end
  end

  // data path
  always_ff @(posedge aclk) begin
    if (load) begin
      if (state == rtp_pkg::PAYLOAD) begin
        if (flush_pend) begin
          m_tdata <= to_wire({carry, 48'h0});
          m_tkeep <= 8'h03;  // two leftover bytes
        end else begin
          m_tdata <= to_wire({carry, pix_be[63:16]});
          m_tkeep <= 8'hFF;
          if (video.valid) begin
            carry <= pix_be[15:0];
          end
        end
      end else begin
        m_tdata <= to_wire(hdr_word);
        m_tkeep <= 8'hFF;
        if (beat_cnt == 3'd7) begin
          carry <= rtp_pkg::RTP_CONT_OFFSET;  // leads the first payload beat
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/rtp_packetizer.sv
// ******************************************************************
// rtp packetizer top
// one eth/ipv4/udp/rtp packet per line of 16-bit video
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rtp_packetizer #(
  parameter int FIFO_DEPTH   = 64,
  parameter int TS_INCREMENT = 3000
) (
  input  wire logic                aclk,
  input  wire logic                aresetn,
  // video in
  input  wire logic                s_axis_tvalid,
  input  wire rtp_pkg::axis_word_t s_axis_tdata,
  input  wire logic                s_axis_tlast,
  input  wire logic                s_axis_tuser,  // start of frame
  output logic                     s_axis_tready,
  // packets out
  output logic                     m_axis_tvalid,
  output rtp_pkg::axis_word_t      m_axis_tdata,
  output rtp_pkg::axis_keep_t      m_axis_tkeep,
  output logic                     m_axis_tlast,
  input  wire logic                m_axis_tready,
  // configuration
  input  wire rtp_pkg::mac_addr_t  dst_mac,
  input  wire rtp_pkg::mac_addr_t  src_mac,
  input  wire rtp_pkg::ip_addr_t   src_ip,
  input  wire rtp_pkg::ip_addr_t   dst_ip,
  input  wire logic [7:0]          ip_tos,
  input  wire rtp_pkg::udp_port_t  src_port,
  input  wire rtp_pkg::udp_port_t  dst_port,
  input  wire rtp_pkg::line_num_t  lines_per_frame,
  input  wire rtp_pkg::pixel_cnt_t px_per_line
);

  video_stream_if video_bus ();
  rtp_hdr_if      hdr_bus ();

  line_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) line_fifo_inst (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .in_valid (s_axis_tvalid),
    .in_data  (s_axis_tdata),
    .in_last  (s_axis_tlast),
    .in_sof   (s_axis_tuser),
    .in_ready (s_axis_tready),
    .out      (video_bus.src)
  );

  rtp_hdr_gen #(
    .TS_INCREMENT (TS_INCREMENT)
  ) rtp_hdr_gen_inst (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .lines_per_frame (lines_per_frame),
    .px_per_line     (px_per_line),
    .ip_tos          (ip_tos),
    .src_ip          (src_ip),
    .dst_ip          (dst_ip),
    .hdr             (hdr_bus.gen)
  );

  rtp_pkt_serializer rtp_pkt_serializer_inst (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .dst_mac     (dst_mac),
    .src_mac     (src_mac),
    .ip_tos      (ip_tos),
    .src_ip      (src_ip),
    .dst_ip      (dst_ip),
    .src_port    (src_port),
    .dst_port    (dst_port),
    .px_per_line (px_per_line),
    .video       (video_bus.dst),
    .hdr         (hdr_bus.ser),
    .m_tvalid    (m_axis_tvalid),
    .m_tdata     (m_axis_tdata),
    .m_tkeep     (m_axis_tkeep),
    .m_tlast     (m_axis_tlast),
    .m_tready    (m_axis_tready)
  );

endmodule

`default_nettype wire

//--- testbench/tb_rtp_packetizer.sv
// ******************************************************************
// rtp packetizer testbench
// replays the golden video lines and checks every packet beat
// in one pass with a free output and one with random tready gaps
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_rtp_packetizer;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int GOLDEN_WORDS = 82;   // 4 config + 12 input + 66 output
  localparam int WAIT_LIMIT   = 200;  // cycles without progress

  logic                aclk;
  logic                aresetn;
  logic                s_axis_tvalid;
  rtp_pkg::axis_word_t s_axis_tdata;
  logic                s_axis_tlast;
  logic                s_axis_tuser;
  logic                s_axis_tready;
  logic                m_axis_tvalid;
  rtp_pkg::axis_word_t m_axis_tdata;
  rtp_pkg::axis_keep_t m_axis_tkeep;
  logic                m_axis_tlast;
  logic                m_axis_tready;
  rtp_pkg::mac_addr_t  dst_mac;
  rtp_pkg::mac_addr_t  src_mac;
  rtp_pkg::ip_addr_t   src_ip;
  rtp_pkg::ip_addr_t   dst_ip;
  logic [7:0]          ip_tos;
  rtp_pkg::udp_port_t  src_port;
  rtp_pkg::udp_port_t  dst_port;
  rtp_pkg::line_num_t  lines_per_frame;
  rtp_pkg::pixel_cnt_t px_per_line;

  logic [79:0]         golden_mem [GOLDEN_WORDS];
  rtp_pkg::axis_word_t in_data_q [$];
  logic                in_last_q [$];
  logic                in_sof_q [$];
  rtp_pkg::axis_word_t exp_data_q [$];  // wire bytes with the first byte leftmost
  rtp_pkg::axis_keep_t exp_keep_q [$];
  logic                exp_last_q [$];

  rtp_packetizer #(
    .FIFO_DEPTH   (64),
    .TS_INCREMENT (3000)
  ) rtp_packetizer_inst (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tlast    (s_axis_tlast),
    .s_axis_tuser    (s_axis_tuser),
    .s_axis_tready   (s_axis_tready),
    .m_axis_tvalid   (m_axis_tvalid),
    .m_axis_tdata    (m_axis_tdata),
    .m_axis_tkeep    (m_axis_tkeep),
    .m_axis_tlast    (m_axis_tlast),
    .m_axis_tready   (m_axis_tready),
    .dst_mac         (dst_mac),
    .src_mac         (src_mac),
    .src_ip          (src_ip),
    .dst_ip          (dst_ip),
    .ip_tos          (ip_tos),
    .src_port        (src_port),
    .dst_port        (dst_port),
    .lines_per_frame (lines_per_frame),
    .px_per_line     (px_per_line)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  // ******************************************************************
  // golden file parsing
  // ******************************************************************
  task automatic load_golden();
    logic [79:0] entry;
    int          i;
    $readmemh("testbench/rtp_packetizer_golden.txt", golden_mem);
    for (i = 0; i < GOLDEN_WORDS; i++) begin
      entry = golden_mem[i];
      case (entry[79:76])
        4'h1: begin
          case (entry[75:72])
            4'h0: dst_mac = entry[47:0];
            4'h1: src_mac = entry[47:0];
            4'h2: {src_ip, dst_ip} = entry[63:0];
            default: begin
              ip_tos          = entry[71:64];
              src_port        = entry[63:48];
              dst_port        = entry[47:32];
              lines_per_frame = entry[31:16];
              px_per_line     = entry[11:0];
            end
          endcase
        end
        4'h2: begin
          in_data_q.push_back(entry[63:0]);
          in_last_q.push_back(entry[72]);
          in_sof_q.push_back(entry[73]);
        end
        4'h3: begin
          exp_data_q.push_back(entry[63:0]);
          exp_keep_q.push_back(entry[71:64]);
          exp_last_q.push_back(entry[72]);
        end
        default: ;  // unread word
      endcase
    end
    if (in_data_q.size() == 0 || exp_data_q.size() == 0) begin
      abort_run("the golden file holds no input or no expected beats");
    end
  endtask

  // ******************************************************************
  // checks
  // ******************************************************************
  task automatic check_beat(input int beat,
                            input rtp_pkg::axis_word_t got_data,
                            input rtp_pkg::axis_keep_t got_keep,
                            input logic got_last,
                            input rtp_pkg::axis_word_t exp_bytes,
                            input rtp_pkg::axis_keep_t exp_keep,
                            input logic exp_last);
    int k;
    if (got_keep !== exp_keep) begin
      abort_run($sformatf("error at %0t ns: beat %0d tkeep %h, expected %h",
                          $time, beat, got_keep, exp_keep));
    end
    if (got_last !== exp_last) begin
      abort_run($sformatf("error at %0t ns: beat %0d tlast %b, expected %b",
                          $time, beat, got_last, exp_last));
    end
    // wire byte k sits in lane k and only enabled lanes count
    for (k = 0; k < 8; k++) begin
      if (exp_keep[k] && (got_data[8*k +: 8] !== exp_bytes[63-8*k -: 8])) begin
        abort_run($sformatf("error at %0t ns: beat %0d byte %0d is %h, expected %h (tdata %h)",
                            $time, beat, k, got_data[8*k +: 8], exp_bytes[63-8*k -: 8],
                            got_data));
      end
    end
  endtask

  task automatic check_idle(input logic got_valid, input logic got_last,
                            input logic got_ready);
    if (got_valid !== 1'b0) begin
      abort_run($sformatf("error at %0t ns: m_axis_tvalid is %b with no packet due",
                          $time, got_valid));
    end
    if (got_last !== 1'b0) begin
      abort_run($sformatf("error at %0t ns: m_axis_tlast is %b with no packet due",
                          $time, got_last));
    end
    if (got_ready !== 1'b1) begin
      abort_run($sformatf("error at %0t ns: s_axis_tready is %b with an empty line FIFO",
                          $time, got_ready));
    end
  endtask

  // ******************************************************************
  // stimulus
  // ******************************************************************
  task automatic apply_reset();
    @(posedge aclk);
    #1;
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    aresetn = 1'b1;
  endtask

  task automatic send_video();
    int beat;
    int waited;
    for (beat = 0; beat < in_data_q.size(); beat++) begin
      s_axis_tvalid = 1'b1;
      s_axis_tdata  = in_data_q[beat];
      s_axis_tlast  = in_last_q[beat];
      s_axis_tuser  = in_sof_q[beat];
      waited = 0;
      @(negedge aclk);
      while (!s_axis_tready) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run($sformatf("input beat %0d was never accepted by the DUT", beat));
        end
        @(negedge aclk);
      end
      @(posedge aclk);  // beat taken at this edge
      #1;
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    s_axis_tuser  = 1'b0;
  endtask

  task automatic receive_packets(input logic gaps);
    int beat;
    int waited;
    beat = 0;
    waited = 0;
    while (beat < exp_data_q.size()) begin
      m_axis_tready = gaps ? (($urandom % 4) != 0) : 1'b1;  // about one gap in four
      @(negedge aclk);
      if (m_axis_tvalid && m_axis_tready) begin
        check_beat(beat, m_axis_tdata, m_axis_tkeep, m_axis_tlast,
                   exp_data_q[beat], exp_keep_q[beat], exp_last_q[beat]);
        beat++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run($sformatf("output beat %0d of %0d never arrived",
                              beat, exp_data_q.size()));
        end
      end
      @(posedge aclk);
      #1;
    end
    m_axis_tready = 1'b0;
  endtask

  task automatic run_pass(input logic gaps);
    int cycle;
    apply_reset();
    for (cycle = 0; cycle < 16; cycle++) begin
      @(negedge aclk);
      check_idle(m_axis_tvalid, m_axis_tlast, s_axis_tready);
    end
    @(posedge aclk);
    #1;
    fork
      send_video();
      receive_packets(gaps);
    join
    for (cycle = 0; cycle < 8; cycle++) begin  // nothing after the last packet
      @(negedge aclk);
      check_idle(m_axis_tvalid, m_axis_tlast, s_axis_tready);
    end
  endtask

  initial begin
    int unsigned seed_state;
    seed_state      = 32'h266f8c93;
    void'($urandom(seed_state));
    aresetn         = 1'b0;
    s_axis_tvalid   = 1'b0;
    s_axis_tdata    = '0;
    s_axis_tlast    = 1'b0;
    s_axis_tuser    = 1'b0;
    m_axis_tready   = 1'b0;
    dst_mac         = '0;
    src_mac         = '0;
    src_ip          = '0;
    dst_ip          = '0;
    ip_tos          = '0;
    src_port        = '0;
    dst_port        = '0;
    lines_per_frame = '0;
    px_per_line     = '0;
    load_golden();
    run_pass(1'b0);
    run_pass(1'b1);  // same stream again under back-pressure
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtp_packetizer.f
src/rtp_pkg.sv
src/video_stream_if.sv
src/rtp_hdr_if.sv
src/line_fifo.sv
src/rtp_hdr_gen.sv
src/rtp_pkt_serializer.sv
src/rtp_packetizer.sv
testbench/tb_rtp_packetizer.sv

//--- Bender.yml
package:
  name: rtp_packetizer

sources:
  - src/rtp_pkg.sv
  - src/video_stream_if.sv
  - src/rtp_hdr_if.sv
  - src/line_fifo.sv
  - src/rtp_hdr_gen.sv
  - src/rtp_pkt_serializer.sv
  - src/rtp_packetizer.sv
  - target: test
    files:
      - testbench/tb_rtp_packetizer.sv

//--- testbench/rtp_packetizer_golden.txt
// each word is 20 hex digits: kind, flags, keep, then 64 data bits
// kind 1 config (flags = field), 2 input beat (bit0 last, bit1 sof), 3 output beat (bit0 last)
// input data is raw tdata, output data lists wire bytes in order with the first byte leftmost
100000001A2B3C4D5E6F 11000000020406080A0C 1200C0A80001C0A80002 13B81388138A00030008
// video in, two frames of three lines, 8 pixels per line
2200A033A022A011A000 2100A077A066A055A044
2000A133A122A111A100 2100A177A166A155A144
2000A233A222A211A200 2100A277A266A255A244
2200A333A322A311A300 2100A377A366A355A344
2000A433A422A411A400 2100A477A466A455A444
2000A533A522A511A500 2100A577A566A555A544
// frame 0 line 0, seq 0, timestamp 0
30FF1A2B3C4D5E6F0204 30FF06080A0C080045B8 30FF004400004000FF11 30FFF99CC0A80001C0A8
30FF00021388138A0030 30FF0000816000000000 30FF0000000000000000 30FF0000000000100000
30FF0000A000A011A022 30FFA033A044A055A066 3103A077000000000000
// frame 0 line 1, seq 1
30FF1A2B3C4D5E6F0204 30FF06080A0C080045B8 30FF004400004000FF11 30FFF99CC0A80001C0A8
30FF00021388138A0030 30FF0000816000010000 30FF0000000000000000 30FF0000000000100001
30FF0000A100A111A122 30FFA133A144A155A166 3103A177000000000000
// frame 0 line 2, seq 2, marker
30FF1A2B3C4D5E6F0204 30FF06080A0C080045B8 30FF004400004000FF11 30FFF99CC0A80001C0A8
30FF00021388138A0030 30FF000081E000020000 30FF0000000000000000 30FF0000000000100002
30FF0000A200A211A222 30FFA233A244A255A266 3103A277000000000000
// frame 1 line 0, seq 3, timestamp 3000
30FF1A2B3C4D5E6F0204 30FF06080A0C080045B8 30FF004400004000FF11 30FFF99CC0A80001C0A8
30FF00021388138A0030 30FF0000816000030000 30FF0BB8000000000000 30FF0000000000100000
30FF0000A300A311A322 30FFA333A344A355A366 3103A377000000000000
// frame 1 line 1, seq 4
30FF1A2B3C4D5E6F0204 30FF06080A0C080045B8 30FF004400004000FF11 30FFF99CC0A80001C0A8
30FF00021388138A0030 30FF0000816000040000 30FF0BB8000000000000 30FF0000000000100001
30FF0000A400A411A422 30FFA433A444A455A466 3103A477000000000000
// frame 1 line 2, seq 5, marker
30FF1A2B3C4D5E6F0204 30FF06080A0C080045B8 30FF004400004000FF11 30FFF99CC0A80001C0A8
30FF00021388138A0030 30FF000081E000050000 30FF0BB8000000000000 30FF0000000000100002
30FF0000A500A511A522 30FFA533A544A555A566 3103A577000000000000
